// ==== verification/cpld_interface_tests.txt ====
# op addr word status rdata    (op W = write, R = read; other columns hex)
# word is the write data, or the miso word the CPLD returns on a CPLD read
R 00000 00000000 0 0C01D1F0
R 00008 00000000 1 00000000
W 00004 DEADBEEF 0 00000000
R 00004 00000000 0 DEADBEEF
W 00000 12345678 0 00000000
R 00000 00000000 0 0C01D1F0
W 08123 CAFEF00D 0 00000000
R 10456 5A3C9617 0 5A3C9617
R 00010 00000000 0 00000002
W 00010 00000005 0 00000000
R 00010 00000000 0 00000005
W 0C004 13579BDF 0 00000000
R 0FFFC 89ABCDEF 0 89ABCDEF
R 00100 00000000 1 00000000
W 18004 11111111 1 00000000
R 17FFC 0F0F0F0F 0 0F0F0F0F

// ==== tb.f ====
src/cpld_if_pkg.sv
src/ctrlport_decoder.sv
src/cpld_base_regs.sv
src/cpld_spi_master.sv
src/cpld_interface.sv
verification/clock_gen.sv
verification/cpld_interface_properties.sv
verification/tb_cpld_interface.sv

// ==== Bender.yml ====
package:
  name: cpld_interface

sources:
  - src/cpld_if_pkg.sv
  - src/ctrlport_decoder.sv
  - src/cpld_base_regs.sv
  - src/cpld_spi_master.sv
  - src/cpld_interface.sv
  - target: test
    files:
      - verification/clock_gen.sv
      - verification/cpld_interface_properties.sv
      - verification/tb_cpld_interface.sv

// ==== verification/tb_cpld_interface.sv ====
// Testbench for cpld_interface; runs the request list from the tests file against a model SPI slave
`timescale 1ns/1ps
`default_nettype none

module tb_cpld_interface
  import cpld_if_pkg::*;
();

  localparam int       RESET_CYCLES = 16;
  localparam clk_div_t DIV_DEFAULT  = 16'd2;

  logic           clk;
  logic           rst_n;
  ctrlport_req_t  req;
  wire            [1:0] ss;
  wire            sclk;
  wire            mosi;
  logic           miso;
  ctrlport_resp_t resp;

  // Test list
  bit             is_wr_q[$];
  ctrlport_addr_t addr_q[$];
  ctrlport_data_t word_q[$];
  logic [1:0]     sts_q[$];
  ctrlport_data_t rdata_q[$];

  int         test_errs;
  int         failed_tests;
  int         cycle_count;
  int         cycle_limit;
  clk_div_t   mb_div;
  clk_div_t   db_div;
  bit         load_ok;

  // SPI slave model state
  ctrlport_data_t miso_word;
  logic [47:0]    shift_in;
  spi_frame_t     rx_frame;
  logic [1:0]     frame_ss;
  int             frame_count;
  int             rise_cnt;
  int             fall_cnt;
  int             half_cycles;
  int             low_cycles;
  realtime        rise_time;
  realtime        fall_time;

  clock_gen #(.PERIOD_NS (4), .RESET_CYCLES (RESET_CYCLES)) clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cpld_interface #(.DIV_RESET (DIV_DEFAULT)) cpld_interface_i (
    .ctrlport_clk (clk),
    .rst_n        (rst_n),
    .req          (req),
    .miso         (miso),
    .resp         (resp),
    .ss           (ss),
    .sclk         (sclk),
    .mosi         (mosi)
  );

  // --------------------------------------------------------------------------
  // SPI slave, mode 0
  // --------------------------------------------------------------------------
  always @(posedge sclk) begin
    if (ss != 2'b11) begin
      rise_time = $realtime;
      // Low half between the first fall and the second rise
      if (rise_cnt == 1) low_cycles = int'(($realtime - fall_time) / 4.0);
      shift_in  = {shift_in[46:0], mosi};
      rise_cnt++;
      if (rise_cnt == 48) begin
        rx_frame = shift_in;
        frame_ss = ss;
        frame_count++;
        rise_cnt = 0;
      end
    end
  end

  // Read word goes out MSB first over the last 32 bits
  always @(negedge sclk) begin
    if (ss != 2'b11) begin
      fall_cnt++;
      if (fall_cnt == 1) begin
        fall_time   = $realtime;
        half_cycles = int'(($realtime - rise_time) / 4.0);
      end
      if (fall_cnt >= 16 && fall_cnt < 48) miso = miso_word[47 - fall_cnt];
      if (fall_cnt == 48) begin
        miso     = 1'b0;
        fall_cnt = 0;
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic bit in_window(ctrlport_addr_t a, ctrlport_addr_t start,
                                   ctrlport_addr_t size);
    return (a >= start) && (a < start + size);
  endfunction

  task automatic compare_value(input string name, input logic [47:0] got,
                               input logic [47:0] exp);
    assert (got === exp)
      else begin
        $display("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        test_errs++;
      end
  endtask

  task automatic load_tests(output bit ok);
    int             fd;
    int             n;
    string          line;
    string          op;
    ctrlport_addr_t a;
    ctrlport_data_t w;
    logic [1:0]     s;
    ctrlport_data_t d;
    ok = 1'b0;
    fd = $fopen("verification/cpld_interface_tests.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h", op, a, w, s, d);
          if (n == 5) begin
            is_wr_q.push_back(op == "W");
            addr_q.push_back(a);
            word_q.push_back(w);
            sts_q.push_back(s);
            rdata_q.push_back(d);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Bound from the slowest divider any test writes
  function automatic int timeout_cycles();
    int max_div;
    max_div = DIV_DEFAULT;
    foreach (addr_q[i]) begin
      if (is_wr_q[i] && (addr_q[i] == BASE_START + REG_MB_CLK_DIV ||
                         addr_q[i] == BASE_START + REG_DB_CLK_DIV)) begin
        if (int'(word_q[i][15:0]) > max_div) max_div = word_q[i][15:0];
      end
    end
    return RESET_CYCLES + addr_q.size() * (48 * 2 * (max_div + 1) + 20);
  endfunction

  task automatic run_request(input int idx);
    bit             wr;
    bit             mb;
    bit             db;
    bit             ss_low;
    int             cycles;
    int             frames_before;
    ctrlport_addr_t a;
    spi_frame_t     exp_frame;
    wr            = is_wr_q[idx];
    a             = addr_q[idx];
    mb            = in_window(a, MB_CPLD_START, CPLD_WINDOW_SIZE);
    db            = in_window(a, DB0_CPLD_START, CPLD_WINDOW_SIZE);
    test_errs     = 0;
    ss_low        = 1'b0;
    cycles        = 0;
    miso_word     = word_q[idx];
    frames_before = frame_count;
    req.wr        = wr;
    req.rd        = !wr;
    req.addr      = a;
    req.data      = wr ? word_q[idx] : '0;
    do begin
      @(negedge clk);
      req = '0;
      cycles++;
      if (ss != 2'b11) ss_low = 1'b1;
    end while (!resp.ack);
    compare_value("resp.status", resp.status, sts_q[idx]);
    compare_value("resp.data", resp.data, rdata_q[idx]);
    if (mb || db) begin
      exp_frame.wr   = wr;
      exp_frame.addr = cpld_addr_t'(a - (db ? DB0_CPLD_START : MB_CPLD_START));
      exp_frame.data = wr ? word_q[idx] : '0;
      assert (frame_count == frames_before + 1)
        else begin
          $display("Expected one SPI frame for test %0d, saw %0d", idx + 1,
                   frame_count - frames_before);
          test_errs++;
        end
      compare_value("mosi frame", rx_frame, exp_frame);
      compare_value("ss", frame_ss, db ? 2'b01 : 2'b10);
      compare_value("sclk half period", half_cycles, (db ? db_div : mb_div) + 1);
      compare_value("sclk low half period", low_cycles, (db ? db_div : mb_div) + 1);
    end else begin
      compare_value("ack latency", cycles, 2);
      assert (!ss_low && frame_count == frames_before)
        else begin
          $display("Slave select went low on a non-CPLD access in test %0d", idx + 1);
          test_errs++;
        end
    end
    // Track the dividers the DUT should now use
    if (wr && a == BASE_START + REG_MB_CLK_DIV) mb_div = word_q[idx][15:0];
    if (wr && a == BASE_START + REG_DB_CLK_DIV) db_div = word_q[idx][15:0];
    if (test_errs != 0) failed_tests++;
    $display("Test %0d %s %05h: %s", idx + 1, wr ? "W" : "R", a,
             test_errs == 0 ? "passed" : "failed");
  endtask

  initial begin
    req          = '0;
    miso         = 1'b0;
    miso_word    = '0;
    shift_in     = '0;
    frame_count  = 0;
    rise_cnt     = 0;
    fall_cnt     = 0;
    half_cycles  = 0;
    low_cycles   = 0;
    rise_time    = 0.0;
    fall_time    = 0.0;
    cycle_count  = 0;
    cycle_limit  = 0;
    failed_tests = 0;
    mb_div       = DIV_DEFAULT;
    db_div       = DIV_DEFAULT;
    load_tests(load_ok);
    if (!load_ok || addr_q.size() == 0) begin
      $display("Could not read any tests from verification/cpld_interface_tests.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      cycle_limit = timeout_cycles();
      wait (rst_n === 1'b1);
      @(negedge clk);
      foreach (addr_q[i]) run_request(i);
      $display("%0d tests run, %0d passed, %0d failed", addr_q.size(),
               addr_q.size() - failed_tests, failed_tests);
      if (failed_tests == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/cpld_interface_properties.sv ====
// Concurrent checks on the control-port and SPI pins, bound into every cpld_interface instance
`timescale 1ns/1ps
`default_nettype none

module cpld_interface_properties
  import cpld_if_pkg::*;
(
  input wire                 ctrlport_clk,
  input wire                 rst_n,
  input wire ctrlport_req_t  req,
  input wire ctrlport_resp_t resp,
  input wire [1:0]           ss,
  input wire                 sclk
);

  // --------------------------------------------------------------------------
  // Control port
  // --------------------------------------------------------------------------
  a_no_wr_and_rd: assert property (@(posedge ctrlport_clk) disable iff (!rst_n)
    !(req.wr && req.rd))
    else $error("wr and rd asserted in the same cycle");

  a_ack_one_cycle: assert property (@(posedge ctrlport_clk) disable iff (!rst_n)
    resp.ack |=> !resp.ack)
    else $error("ack held for more than one cycle");

  // --------------------------------------------------------------------------
  // SPI pins
  // --------------------------------------------------------------------------
  a_one_slave: assert property (@(posedge ctrlport_clk) disable iff (!rst_n)
    ss != 2'b00)
    else $error("both slave selects low");

  a_sclk_idle_low: assert property (@(posedge ctrlport_clk) disable iff (!rst_n)
    (ss == 2'b11) |-> !sclk)
    else $error("sclk high with no slave selected");

endmodule

bind cpld_interface cpld_interface_properties cpld_interface_properties_i (
  .ctrlport_clk (ctrlport_clk),
  .rst_n        (rst_n),
  .req          (req),
  .resp         (resp),
  .ss           (ss),
  .sclk         (sclk)
);

`default_nettype wire

// ==== verification/clock_gen.sv ====
// Testbench clock and reset source; a 4 ns clock with rst_n held low for the first 16 cycles
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2.0) clk = ~clk;
  end

  // Release on a falling edge, in step with the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== src/cpld_interface.sv ====
// Top level of the motherboard CPLD interface joining decoder, base registers and SPI master
`timescale 1ns/1ps
`default_nettype none

module cpld_interface
  import cpld_if_pkg::*;
#(
  parameter clk_div_t DIV_RESET = 16'd2
) (
  input  wire                 ctrlport_clk,
  input  wire                 rst_n,
  input  wire ctrlport_req_t  req,
  input  wire                 miso,
  output wire ctrlport_resp_t resp,
  output wire [1:0]           ss,
  output wire                 sclk,
  output wire                 mosi
);

  wire ctrlport_req_t  base_req;
  wire ctrlport_req_t  spi_req;
  wire ctrlport_resp_t base_resp;
  wire ctrlport_resp_t spi_resp;
  wire clk_div_t       mb_clk_div;
  wire clk_div_t       db_clk_div;

  ctrlport_decoder ctrlport_decoder_i (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (req),
    .base_resp    (base_resp),
    .spi_resp     (spi_resp),
    .base_req     (base_req),
    .spi_req      (spi_req),
    .resp         (resp)
  );

  cpld_base_regs #(.DIV_RESET (DIV_RESET)) cpld_base_regs_i (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (base_req),
    .resp         (base_resp),
    .mb_clk_div   (mb_clk_div),
    .db_clk_div   (db_clk_div)
  );

  cpld_spi_master cpld_spi_master_i (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .req          (spi_req),
    .mb_clk_div   (mb_clk_div),
    .db_clk_div   (db_clk_div),
    .miso         (miso),
    .resp         (spi_resp),
    .ss           (ss),
    .sclk         (sclk),
    .mosi         (mosi)
  );

endmodule

`default_nettype wire

// ==== src/cpld_spi_master.sv ====
// SPI master that turns one control-port request into a 48-bit mode 0 frame to the MB or DB0 CPLD
`timescale 1ns/1ps
`default_nettype none

module cpld_spi_master
  import cpld_if_pkg::*;
(
  input  wire                ctrlport_clk,
  input  wire                rst_n,
  input  wire ctrlport_req_t req,
  input  wire clk_div_t      mb_clk_div,
  input  wire clk_div_t      db_clk_div,
  input  wire                miso,
  output ctrlport_resp_t     resp,
  output logic [1:0]         ss,
  output logic               sclk,
  output wire                mosi
);

  localparam int FRAME_BITS = $bits(spi_frame_t);
  localparam int DATA_BITS  = $bits(ctrlport_data_t);

  spi_state_e     state;
  spi_frame_t     frame;
  spi_frame_t     shift_q;
  ctrlport_addr_t win_start;
  ctrlport_addr_t offset;
  clk_div_t       div_q;
  clk_div_t       half_cnt;
  logic [5:0]     bit_cnt;
  ctrlport_data_t rx_data;
  logic           rd_q;
  logic           start;
  logic           sel_db;
  logic           half_done;
  logic           rise;
  logic           fall;

  // --------------------------------------------------------------------------
  // Frame assembly
  // --------------------------------------------------------------------------
  assign start     = (state == idle) && (req.wr || req.rd);
  assign sel_db    = req.addr >= DB0_CPLD_START;
  assign win_start = sel_db ? DB0_CPLD_START : MB_CPLD_START;
  assign offset    = req.addr - win_start;

  // Reads carry a zero data field
  assign frame = '{
    wr:   req.wr,
    addr: offset[$bits(cpld_addr_t)-1:0],
    data: req.wr ? req.data : '0
  };

  // --------------------------------------------------------------------------
  // Bit timing
  // --------------------------------------------------------------------------
  assign half_done = half_cnt == div_q;
  assign rise      = half_done && !sclk;
  assign fall      = half_done && sclk;
  assign mosi      = shift_q[FRAME_BITS-1];

  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      state    <= idle;
      ss       <= 2'b11;
      sclk     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      shift_q  <= '0;
      resp     <= '0;
    end else begin
      resp <= '0;
      case (state)
        idle: begin
          if (start) begin
            ss       <= sel_db ? 2'b01 : 2'b10;
            shift_q  <= frame;
            half_cnt <= '0;
            bit_cnt  <= '0;
            state    <= shift;
          end
        end
        shift: begin
          half_cnt <= half_done ? '0 : half_cnt + 1'b1;
          if (rise) sclk <= 1'b1;
          // Next bit goes out while sclk is low
          if (fall) begin
            sclk    <= 1'b0;
            shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 6'(FRAME_BITS - 1)) state <= done;
          end
        end
        done: begin
          ss          <= 2'b11;
          resp.ack    <= 1'b1;
          resp.status <= sts_okay;
          resp.data   <= rd_q ? rx_data : '0;
          state       <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Divider and direction held for the whole frame
  always_ff @(posedge ctrlport_clk) begin
    if (start) begin
      div_q <= sel_db ? db_clk_div : mb_clk_div;
      rd_q  <= req.rd;
    end
    // Read word arrives in the data field of the frame
    if (state == shift && rise && bit_cnt >= 6'(FRAME_BITS - DATA_BITS)) begin
      rx_data <= {rx_data[DATA_BITS-2:0], miso};
    end
  end

endmodule

`default_nettype wire

// ==== src/cpld_base_regs.sv ====
// Base register block holding signature, scratch and the SPI clock dividers on the control port
`timescale 1ns/1ps
`default_nettype none

module cpld_base_regs
  import cpld_if_pkg::*;
#(
  parameter clk_div_t DIV_RESET = 16'd2
) (
  input  wire                ctrlport_clk,
  input  wire                rst_n,
  input  wire ctrlport_req_t req,
  output ctrlport_resp_t     resp,
  output clk_div_t           mb_clk_div,
  output clk_div_t           db_clk_div
);

  ctrlport_addr_t offset;
  ctrlport_data_t scratch;
  ctrlport_data_t rd_data;
  logic           known;

  assign offset = req.addr - BASE_START;

  always_comb begin
    known   = 1'b1;
    rd_data = '0;
    case (offset)
      REG_SIGNATURE:  rd_data = SIGNATURE_VALUE;
      REG_SCRATCH:    rd_data = scratch;
      REG_MB_CLK_DIV: rd_data = {{($bits(ctrlport_data_t) - $bits(clk_div_t)){1'b0}}, mb_clk_div};
      REG_DB_CLK_DIV: rd_data = {{($bits(ctrlport_data_t) - $bits(clk_div_t)){1'b0}}, db_clk_div};
      default:        known = 1'b0;
    endcase
  end

  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      resp       <= '0;
      scratch    <= '0;
      mb_clk_div <= DIV_RESET;
      db_clk_div <= DIV_RESET;
    end else begin
      resp <= '0;
      if (req.wr || req.rd) begin
        resp.ack    <= 1'b1;
        resp.status <= known ? sts_okay : sts_cmderr;
        if (req.rd) resp.data <= rd_data;
      end
      // Signature and unknown offsets swallow writes
      if (req.wr) begin
        case (offset)
          REG_SCRATCH:    scratch    <= req.data;
          REG_MB_CLK_DIV: mb_clk_div <= req.data[$bits(clk_div_t)-1:0];
          REG_DB_CLK_DIV: db_clk_div <= req.data[$bits(clk_div_t)-1:0];
          default:        ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/ctrlport_decoder.sv ====
// Window decoder that routes each registered request to its target and terminates unowned addresses
`timescale 1ns/1ps
`default_nettype none

module ctrlport_decoder
  import cpld_if_pkg::*;
(
  input  wire                 ctrlport_clk,
  input  wire                 rst_n,
  input  wire ctrlport_req_t  req,
  input  wire ctrlport_resp_t base_resp,
  input  wire ctrlport_resp_t spi_resp,
  output ctrlport_req_t       base_req,
  output ctrlport_req_t       spi_req,
  output ctrlport_resp_t      resp
);

  logic           strobe;
  logic           base_hit;
  logic           mb_hit;
  logic           db0_hit;
  logic           spi_hit;
  logic           base_wr_q;
  logic           base_rd_q;
  logic           spi_wr_q;
  logic           spi_rd_q;
  logic           term_q;
  logic           term_ack;
  ctrlport_addr_t addr_q;
  ctrlport_data_t data_q;
  ctrlport_resp_t term_resp;

  assign strobe   = req.wr | req.rd;
  assign base_hit = (req.addr >= BASE_START) && (req.addr < BASE_START + BASE_SIZE);
  assign mb_hit   = (req.addr >= MB_CPLD_START) &&
                    (req.addr < MB_CPLD_START + CPLD_WINDOW_SIZE);
  assign db0_hit  = (req.addr >= DB0_CPLD_START) &&
                    (req.addr < DB0_CPLD_START + CPLD_WINDOW_SIZE);
  assign spi_hit  = mb_hit | db0_hit;

  // Strobes go only to the owning target
  always_ff @(posedge ctrlport_clk) begin
    if (!rst_n) begin
      base_wr_q <= 1'b0;
      base_rd_q <= 1'b0;
      spi_wr_q  <= 1'b0;
      spi_rd_q  <= 1'b0;
      term_q    <= 1'b0;
      term_ack  <= 1'b0;
    end else begin
      base_wr_q <= req.wr & base_hit;
      base_rd_q <= req.rd & base_hit;
      spi_wr_q  <= req.wr & spi_hit;
      spi_rd_q  <= req.rd & spi_hit;
      // Second stage keeps termination in step with the base block
      term_q    <= strobe & ~(base_hit | spi_hit);
      term_ack  <= term_q;
    end
  end

  always_ff @(posedge ctrlport_clk) begin
    addr_q <= req.addr;
    data_q <= req.data;
  end

  assign base_req = '{wr: base_wr_q, rd: base_rd_q, addr: addr_q, data: data_q};
  assign spi_req  = '{wr: spi_wr_q, rd: spi_rd_q, addr: addr_q, data: data_q};

  assign term_resp = '{ack: term_ack, status: term_ack ? sts_cmderr : sts_okay, data: '0};

  // Idle targets drive all zeros, and only one acks at a time
  assign resp = base_resp | spi_resp | term_resp;

endmodule

`default_nettype wire

// ==== src/cpld_if_pkg.sv ====
// Shared control-port types, address map and SPI frame layout, imported by every CPLD interface module
`default_nettype none

package cpld_if_pkg;

  // --------------------------------------------------------------------------
  // Control port
  // --------------------------------------------------------------------------
  typedef logic [19:0] ctrlport_addr_t;
  typedef logic [31:0] ctrlport_data_t;

  typedef enum logic [1:0] {
    sts_okay   = 2'd0,
    sts_cmderr = 2'd1
  } ctrlport_status_e;

  typedef struct packed {
    logic           wr;
    logic           rd;
    ctrlport_addr_t addr;
    ctrlport_data_t data;
  } ctrlport_req_t;

  typedef struct packed {
    logic             ack;
    ctrlport_status_e status;
    ctrlport_data_t   data;
  } ctrlport_resp_t;

  // Address windows seen from the application port
  localparam ctrlport_addr_t BASE_START       = 20'h00000;
  localparam ctrlport_addr_t BASE_SIZE        = 20'h00040;
  localparam ctrlport_addr_t MB_CPLD_START    = 20'h08000;
  localparam ctrlport_addr_t DB0_CPLD_START   = 20'h10000;
  localparam ctrlport_addr_t CPLD_WINDOW_SIZE = 20'h08000;

  // Base register offsets
  localparam ctrlport_addr_t REG_SIGNATURE  = 20'h00;
  localparam ctrlport_addr_t REG_SCRATCH    = 20'h04;
  localparam ctrlport_addr_t REG_MB_CLK_DIV = 20'h10;
  localparam ctrlport_addr_t REG_DB_CLK_DIV = 20'h14;

  localparam ctrlport_data_t SIGNATURE_VALUE = 32'h0C01_D1F0;

  // --------------------------------------------------------------------------
  // SPI link to the CPLDs
  // --------------------------------------------------------------------------
  typedef logic [15:0] clk_div_t;
  typedef logic [14:0] cpld_addr_t;

  // Sent MSB first, write flag leads
  typedef struct packed {
    logic           wr;
    cpld_addr_t     addr;
    ctrlport_data_t data;
  } spi_frame_t;

  typedef enum logic [1:0] {idle, shift, done} spi_state_e;

endpackage

`default_nettype wire
